// File: verilog/dct_pkg.sv
// Block geometry, data widths, credit depths, register map and zigzag order
`default_nettype none

package dct_pkg;

    // Block geometry
    localparam int BLK_DIM = 4;
    localparam int BLK_PIX = BLK_DIM * BLK_DIM;

    // Data widths
    localparam int PIX_W   = 8;
    localparam int COEF_W  = 14;
    localparam int OUT_W   = 11;
    localparam int IDX_W   = 4;
    localparam int SHIFT_W = 3;

    // Upstream holds two full banks worth of credits after reset
    localparam int PIXEL_CREDITS = 2 * BLK_PIX;
    localparam int OUT_CREDITS   = 4;

    // Register map
    localparam logic [1:0] REG_CTRL   = 2'd0;
    localparam logic [1:0] REG_STATUS = 2'd1;

    // Raster index of the coefficient sent at each zigzag position
    localparam logic [IDX_W-1:0] ZIGZAG [BLK_PIX] = '{
        4'd0,
        4'd1,
        4'd4,
        4'd8,
        4'd5,
        4'd2,
        4'd3,
        4'd6,
        4'd9,
        4'd12,
        4'd13,
        4'd10,
        4'd7,
        4'd11,
        4'd14,
        4'd15
    };

endpackage

`default_nettype wire

// File: verilog/dct_ifs.sv
// Pixel block and coefficient block interfaces between the pipeline stages
`timescale 1ns/1ps
`default_nettype none

// One full bank of pixels, raster order
interface block_if import dct_pkg::*; ();

    logic                            valid;
    logic                            ready;
    logic [BLK_PIX-1:0][PIX_W-1:0]   pixels;
    logic                            bank;

    modport source (output valid, output pixels, output bank, input ready);
    modport sink   (input valid, input pixels, input bank, output ready);

endinterface

// One transformed block, raster order, signed coefficients
interface coeff_block_if import dct_pkg::*; ();

    logic                            valid;
    logic                            ready;
    logic [BLK_PIX-1:0][COEF_W-1:0]  coefs;

    modport source (output valid, output coefs, input ready);
    modport sink   (input valid, input coefs, output ready);

endinterface

`default_nettype wire

// File: verilog/block_buffer.sv
// Double-banked pixel buffer that assembles 4x4 blocks and returns input credits
`timescale 1ns/1ps
`default_nettype none

module block_buffer import dct_pkg::*; (
    input  logic             clk,
    input  logic             reset,
    input  logic [PIX_W-1:0] pixel_in,
    input  logic             pixel_valid,
    output logic             pixel_credit,
    block_if.source          blk
);

    // Two banks, each holding one block in raster order
    logic [1:0][BLK_PIX-1:0][PIX_W-1:0] bank_mem;

    logic [$clog2(BLK_DIM)-1:0] row_ptr;
    logic [$clog2(BLK_DIM)-1:0] col_ptr;
    logic                       wr_bank;
    logic                       rd_bank;
    logic [1:0]                 bank_full;
    logic                       last_pixel;
    logic                       handoff;

    // Two handoffs may queue their returns, so room for 32
    logic [$clog2(2*BLK_PIX+1)-1:0] credit_pend;
    logic [$clog2(2*BLK_PIX+1)-1:0] credit_next;

    assign last_pixel = pixel_valid && (&row_ptr) && (&col_ptr);

    // Banks are offered in the order they were filled
    assign blk.valid  = bank_full[rd_bank];
    assign blk.pixels = bank_mem[rd_bank];
    assign blk.bank   = rd_bank;
    assign handoff    = blk.valid && blk.ready;

    always_ff @(posedge clk) begin
        if (pixel_valid) begin
            bank_mem[wr_bank][{row_ptr, col_ptr}] <= pixel_in;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            row_ptr   <= '0;
            col_ptr   <= '0;
            wr_bank   <= 1'b0;
            rd_bank   <= 1'b0;
            bank_full <= '0;
        end else begin
            if (pixel_valid) begin
                col_ptr <= col_ptr + 1'b1;
                if (&col_ptr) begin
                    row_ptr <= row_ptr + 1'b1;
                end
            end
            if (handoff) begin
                bank_full[rd_bank] <= 1'b0;
                rd_bank            <= ~rd_bank;
            end
            // Upstream credits keep it from writing into a bank still full
            if (last_pixel) begin
                bank_full[wr_bank] <= 1'b1;
                wr_bank            <= ~wr_bank;
            end
        end
    end

    // A handoff frees all 16 slots of the bank at once
    assign credit_next = credit_pend + (handoff ? BLK_PIX[$bits(credit_next)-1:0] : '0);

    // Hand back one credit per cycle until the queue drains
    always_ff @(posedge clk) begin
        if (reset) begin
            credit_pend  <= '0;
            pixel_credit <= 1'b0;
        end else if (credit_next != '0) begin
            credit_pend  <= credit_next - 1'b1;
            pixel_credit <= 1'b1;
        end else begin
            credit_pend  <= '0;
            pixel_credit <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: verilog/block_transform.sv
// Two-stage pipelined 4x4 integer forward core transform with level shift
`timescale 1ns/1ps
`default_nettype none

module block_transform import dct_pkg::*; (
    input  logic          clk,
    input  logic          reset,
    block_if.sink         blk,
    coeff_block_if.source coefs
);

    logic                           s1_valid;
    logic                           s2_valid;
    logic [BLK_PIX-1:0][COEF_W-1:0] s1_data;
    logic [BLK_PIX-1:0][COEF_W-1:0] s2_data;
    logic [BLK_PIX-1:0][COEF_W-1:0] row_result;
    logic [BLK_PIX-1:0][COEF_W-1:0] col_result;
    logic                           s2_free;
    logic                           s2_load;

    // Butterfly form of rows (1,1,1,1) (2,1,-1,-2) (1,-1,-1,1) (1,-2,2,-1)
    function automatic logic [BLK_DIM-1:0][COEF_W-1:0] core_1d(
        input logic [BLK_DIM-1:0][COEF_W-1:0] x
    );
        logic signed [COEF_W-1:0]      s0;
        logic signed [COEF_W-1:0]      s1;
        logic signed [COEF_W-1:0]      d0;
        logic signed [COEF_W-1:0]      d1;
        logic [BLK_DIM-1:0][COEF_W-1:0] y;
        s0   = $signed(x[0]) + $signed(x[3]);
        s1   = $signed(x[1]) + $signed(x[2]);
        d0   = $signed(x[0]) - $signed(x[3]);
        d1   = $signed(x[1]) - $signed(x[2]);
        y[0] = s0 + s1;
        y[1] = (d0 <<< 1) + d1;
        y[2] = s0 - s1;
        y[3] = d0 - (d1 <<< 1);
        return y;
    endfunction

    // Stage one works on rows of the level-shifted block
    always_comb begin
        logic [BLK_DIM-1:0][COEF_W-1:0] row_in;
        logic signed [COEF_W-1:0]       shifted;
        for (int r = 0; r < BLK_DIM; r++) begin
            for (int c = 0; c < BLK_DIM; c++) begin
                // Subtracting 128 is the same as flipping the MSB
                shifted = $signed({~blk.pixels[r*BLK_DIM+c][PIX_W-1],
                                   blk.pixels[r*BLK_DIM+c][PIX_W-2:0]});
                row_in[c] = shifted;
            end
            row_result[r*BLK_DIM +: BLK_DIM] = core_1d(row_in);
        end
    end

    // Stage two works on columns of the stage one result
    always_comb begin
        logic [BLK_DIM-1:0][COEF_W-1:0] col_in;
        logic [BLK_DIM-1:0][COEF_W-1:0] col_out;
        for (int c = 0; c < BLK_DIM; c++) begin
            for (int r = 0; r < BLK_DIM; r++) begin
                col_in[r] = s1_data[r*BLK_DIM+c];
            end
            col_out = core_1d(col_in);
            for (int r = 0; r < BLK_DIM; r++) begin
                col_result[r*BLK_DIM+c] = col_out[r];
            end
        end
    end

    // A stage advances only when the one after it is empty or draining
    assign s2_free     = !s2_valid || coefs.ready;
    assign s2_load     = s1_valid && s2_free;
    assign blk.ready   = !s1_valid || s2_free;
    assign coefs.valid = s2_valid;
    assign coefs.coefs = s2_data;

    always_ff @(posedge clk) begin
        if (blk.ready) begin
            s1_data <= row_result;
        end
        if (s2_load) begin
            s2_data <= col_result;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
        end else begin
            if (blk.ready) begin
                s1_valid <= blk.valid;
            end
            if (s2_free) begin
                s2_valid <= s1_valid;
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/coeff_quantizer.sv
// Zigzag serializer with rounding quantizer, saturation and output credit counter
`timescale 1ns/1ps
`default_nettype none

module coeff_quantizer import dct_pkg::*; (
    input  logic                     clk,
    input  logic                     reset,
    coeff_block_if.sink              coefs,
    input  logic                     enable,
    input  logic [SHIFT_W-1:0]       quant_shift,
    input  logic                     out_credit,
    output logic signed [OUT_W-1:0]  dct_out,
    output logic                     dct_valid,
    output logic [IDX_W-1:0]         coeff_idx,
    output logic                     coeff_last
);

    logic [BLK_PIX-1:0][COEF_W-1:0]      held;
    logic                                busy;
    logic [IDX_W-1:0]                    pos;
    logic [$clog2(OUT_CREDITS+1)-1:0]    credits;
    logic                                send;
    logic                                last_pos;
    logic [IDX_W-1:0]                    raster_idx;

    // Round half away from zero, then clamp to +-1023
    function automatic logic signed [OUT_W-1:0] quantize(
        input logic signed [COEF_W-1:0] c,
        input logic [SHIFT_W-1:0]       sh
    );
        logic [COEF_W:0]  mag;
        logic [COEF_W:0]  half;
        logic [COEF_W:0]  q;
        logic [COEF_W:0]  q_max;
        logic [OUT_W-1:0] sat;
        q_max = (COEF_W+1)'((1 << (OUT_W - 1)) - 1);
        mag   = c[COEF_W-1] ? -{c[COEF_W-1], c} : {c[COEF_W-1], c};
        half  = (sh == '0) ? '0 : ((COEF_W+1)'(1) << (sh - 1'b1));
        q     = (mag + half) >> sh;
        if (q > q_max) begin
            q = q_max;
        end
        sat = q[OUT_W-1:0];
        return c[COEF_W-1] ? -$signed(sat) : $signed(sat);
    endfunction

    assign last_pos   = &pos;
    assign raster_idx = ZIGZAG[pos];
    assign send       = busy && enable && (credits != '0);

    // Next block loads while the last beat of the current one goes out
    assign coefs.ready = !busy || (send && last_pos);

    always_ff @(posedge clk) begin
        if (coefs.valid && coefs.ready) begin
            held <= coefs.coefs;
        end
        if (send) begin
            dct_out   <= quantize(held[raster_idx], quant_shift);
            coeff_idx <= raster_idx;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            busy       <= 1'b0;
            pos        <= '0;
            dct_valid  <= 1'b0;
            coeff_last <= 1'b0;
        end else begin
            dct_valid  <= send;
            coeff_last <= send && last_pos;
            if (coefs.valid && coefs.ready) begin
                busy <= 1'b1;
                pos  <= '0;
            end else if (send) begin
                pos <= pos + 1'b1;
                if (last_pos) begin
                    busy <= 1'b0;
                end
            end
        end
    end

    // A returned credit and a spent one in the same cycle cancel out
    always_ff @(posedge clk) begin
        if (reset) begin
            credits <= OUT_CREDITS[$bits(credits)-1:0];
        end else begin
            case ({out_credit, send})
                2'b10:   credits <= credits + 1'b1;
                2'b01:   credits <= credits - 1'b1;
                default: credits <= credits;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: verilog/compressor_regs.sv
// Control register, finished block counter and registered readback
`timescale 1ns/1ps
`default_nettype none

module compressor_regs import dct_pkg::*; (
    input  logic               clk,
    input  logic               reset,
    input  logic               cfg_write,
    input  logic [1:0]         cfg_addr,
    input  logic [7:0]         cfg_wdata,
    output logic [7:0]         cfg_rdata,
    input  logic               block_done,
    output logic               enable,
    output logic [SHIFT_W-1:0] quant_shift
);

    // Wraps at 256
    logic [7:0] block_count;

    // Control register holds enable in bit 0 and the shift in bits 3..1
    always_ff @(posedge clk) begin
        if (reset) begin
            enable      <= 1'b1;
            quant_shift <= '0;
        end else if (cfg_write && cfg_addr == REG_CTRL) begin
            enable      <= cfg_wdata[0];
            quant_shift <= cfg_wdata[SHIFT_W:1];
        end
    end

    // Status is read only
    always_ff @(posedge clk) begin
        if (reset) begin
            block_count <= '0;
        end else if (block_done) begin
            block_count <= block_count + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            cfg_rdata <= '0;
        end else begin
            case (cfg_addr)
                REG_CTRL:   cfg_rdata <= {{(7 - SHIFT_W){1'b0}}, quant_shift, enable};
                REG_STATUS: cfg_rdata <= block_count;
                default:    cfg_rdata <= '0;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: verilog/dct_compressor.sv
// Top level of the 4x4 block transform compressor
`timescale 1ns/1ps
`default_nettype none

module dct_compressor import dct_pkg::*; (
    input  logic                    clk,
    input  logic                    reset,
    // Pixel stream with credit return
    input  logic [PIX_W-1:0]        pixel_in,
    input  logic                    pixel_valid,
    output logic                    pixel_credit,
    // Coefficient stream with credit input
    input  logic                    out_credit,
    output logic signed [OUT_W-1:0] dct_out,
    output logic                    dct_valid,
    output logic [IDX_W-1:0]        coeff_idx,
    output logic                    coeff_last,
    // Register port
    input  logic                    cfg_write,
    input  logic [1:0]              cfg_addr,
    input  logic [7:0]              cfg_wdata,
    output logic [7:0]              cfg_rdata
);

    logic               enable;
    logic [SHIFT_W-1:0] quant_shift;
    logic               block_done;

    block_if       blk_bus ();
    coeff_block_if coef_bus ();

    // One block counts as done when its last coefficient leaves
    assign block_done = dct_valid && coeff_last;

    block_buffer buffer_i (
        .clk          (clk),
        .reset        (reset),
        .pixel_in     (pixel_in),
        .pixel_valid  (pixel_valid),
        .pixel_credit (pixel_credit),
        .blk          (blk_bus.source)
    );

    block_transform transform_i (
        .clk   (clk),
        .reset (reset),
        .blk   (blk_bus.sink),
        .coefs (coef_bus.source)
    );

    coeff_quantizer quantizer_i (
        .clk         (clk),
        .reset       (reset),
        .coefs       (coef_bus.sink),
        .enable      (enable),
        .quant_shift (quant_shift),
        .out_credit  (out_credit),
        .dct_out     (dct_out),
        .dct_valid   (dct_valid),
        .coeff_idx   (coeff_idx),
        .coeff_last  (coeff_last)
    );

    compressor_regs regs_i (
        .clk         (clk),
        .reset       (reset),
        .cfg_write   (cfg_write),
        .cfg_addr    (cfg_addr),
        .cfg_wdata   (cfg_wdata),
        .cfg_rdata   (cfg_rdata),
        .block_done  (block_done),
        .enable      (enable),
        .quant_shift (quant_shift)
    );

endmodule

`default_nettype wire

// File: tests/clock_gen.sv
// Testbench clock and synchronous reset generator
`timescale 1ns/1ps
`default_nettype none

module clock_gen (
    output logic clk,
    output logic reset
);

    // 100 ns period
    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Reset spans 8 rising edges and drops just after the last one
    initial begin
        reset = 1'b1;
        repeat (8) @(posedge clk);
        #10;
        reset = 1'b0;
    end

endmodule

`default_nettype wire

// File: tests/dct_monitor.sv
// Output beat checker with expected queue, output credit and pixel credit checks
`timescale 1ns/1ps
`default_nettype none

module dct_monitor import dct_pkg::*; (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    pixel_valid,
    input  logic                    pixel_credit,
    input  logic                    out_credit,
    input  logic signed [OUT_W-1:0] dct_out,
    input  logic                    dct_valid,
    input  logic [IDX_W-1:0]        coeff_idx,
    input  logic                    coeff_last,
    input  logic                    paused,
    output int                      beat_count,
    output int                      error_count
);

    // Expected beat packed as {last, idx, value}
    logic [OUT_W+IDX_W:0] exp_q [$];
    logic [OUT_W+IDX_W:0] exp_beat;
    int                   returned;
    int                   pix_credits;

    task automatic expect_beat(
        input logic [OUT_W-1:0] value,
        input logic [IDX_W-1:0] idx,
        input logic             last
    );
        exp_q.push_back({last, idx, value});
    endtask

    always @(posedge clk) begin
        if (reset) begin
            beat_count  = 0;
            error_count = 0;
            returned    = 0;
            pix_credits = PIXEL_CREDITS;
        end else begin
            // Upstream side
            if (pixel_valid && pix_credits == 0) begin
                $display("Pixel sent while the upstream held no credit");
                error_count++;
            end
            pix_credits = pix_credits + int'(pixel_credit) - int'(pixel_valid);
            if (pix_credits > PIXEL_CREDITS) begin
                $display("More pixel credits returned than were ever spent");
                error_count++;
            end

            // Downstream side
            if (out_credit) begin
                returned++;
            end
            if (coeff_last && !dct_valid) begin
                $display("coeff_last high while dct_valid is low");
                error_count++;
            end
            if (dct_valid) begin
                beat_count++;
                if (paused) begin
                    $display("dct_valid high while output is disabled");
                    error_count++;
                end
                if (beat_count > OUT_CREDITS + returned) begin
                    $display("Beat %0d sent without an output credit", beat_count);
                    error_count++;
                end
                if (exp_q.size() == 0) begin
                    $display("Beat %0d arrived with nothing expected", beat_count);
                    error_count++;
                end else begin
                    exp_beat = exp_q.pop_front();
                    if (dct_out !== exp_beat[OUT_W-1:0]) begin
                        $display("MISMATCH dct_out beat %0d: expected %h, got %h",
                                 beat_count, exp_beat[OUT_W-1:0], dct_out);
                        error_count++;
                    end
                    if (coeff_idx !== exp_beat[OUT_W+IDX_W-1:OUT_W]) begin
                        $display("MISMATCH coeff_idx beat %0d: expected %h, got %h",
                                 beat_count, exp_beat[OUT_W+IDX_W-1:OUT_W], coeff_idx);
                        error_count++;
                    end
                    if (coeff_last !== exp_beat[OUT_W+IDX_W]) begin
                        $display("MISMATCH coeff_last beat %0d: expected %h, got %h",
                                 beat_count, exp_beat[OUT_W+IDX_W], coeff_last);
                        error_count++;
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: tests/tb_dct_compressor.sv
// Testbench top with stimulus table, credit models, reference transform and report
`timescale 1ns/1ps
`default_nettype none

module tb_dct_compressor import dct_pkg::*; ();

    localparam logic [1:0] FILL_CONST = 2'd0;
    localparam logic [1:0] FILL_RAMP  = 2'd1;
    localparam logic [1:0] FILL_RAND  = 2'd2;
    localparam int         NROWS      = 9;
    localparam int         WAIT_LIMIT = 4000;

    typedef struct packed {
        logic [1:0]         mode;
        logic [7:0]         value;
        logic [2:0]         shift;
        logic [7:0]         pause;
        logic [7:0]         gap;
        logic               dc_check;
        logic signed [11:0] dc_exp;
    } row_t;

    // mode, value or ramp step, shift, enable-off cycles, credit gap, DC known, DC
    localparam row_t ROWS [NROWS] = '{
        '{FILL_CONST, 8'd128, 3'd0, 8'd0,  8'd0, 1'b1, 12'sd0},
        '{FILL_CONST, 8'd255, 3'd0, 8'd0,  8'd0, 1'b1, 12'sd1023},
        '{FILL_RAMP,  8'd16,  3'd0, 8'd0,  8'd2, 1'b1, -12'sd128},
        '{FILL_RAND,  8'd0,   3'd0, 8'd0,  8'd3, 1'b0, 12'sd0},
        '{FILL_CONST, 8'd255, 3'd3, 8'd0,  8'd0, 1'b1, 12'sd254},
        '{FILL_RAND,  8'd0,   3'd3, 8'd12, 8'd0, 1'b0, 12'sd0},
        '{FILL_RAND,  8'd0,   3'd1, 8'd0,  8'd6, 1'b0, 12'sd0},
        '{FILL_RAMP,  8'd16,  3'd2, 8'd6,  8'd1, 1'b1, -12'sd32},
        '{FILL_CONST, 8'd0,   3'd1, 8'd0,  8'd0, 1'b1, -12'sd1023}
    };

    // Core transform matrix
    localparam int CORE [BLK_DIM][BLK_DIM] = '{
        '{1, 1, 1, 1},
        '{2, 1, -1, -2},
        '{1, -1, -1, 1},
        '{1, -2, 2, -1}
    };

    logic                    clk;
    logic                    reset;
    logic [PIX_W-1:0]        pixel_in;
    logic                    pixel_valid;
    logic                    pixel_credit;
    logic                    out_credit;
    logic signed [OUT_W-1:0] dct_out;
    logic                    dct_valid;
    logic [IDX_W-1:0]        coeff_idx;
    logic                    coeff_last;
    logic                    cfg_write;
    logic [1:0]              cfg_addr;
    logic [7:0]              cfg_wdata;
    logic [7:0]              cfg_rdata;
    logic                    paused;
    int                      beat_count;
    int                      mon_errors;
    int                      other_errors = 0;
    int                      up_credits;
    int                      expected_total = 0;
    int                      credit_gap = 0;
    int                      owed;
    int                      gap_cnt;
    logic [2:0]              cur_shift = 3'd0;
    logic [31:0]             rng = 32'hf5ea_491b;

    clock_gen clk_i (
        .clk   (clk),
        .reset (reset)
    );

    dct_compressor dut_i (
        .clk          (clk),
        .reset        (reset),
        .pixel_in     (pixel_in),
        .pixel_valid  (pixel_valid),
        .pixel_credit (pixel_credit),
        .out_credit   (out_credit),
        .dct_out      (dct_out),
        .dct_valid    (dct_valid),
        .coeff_idx    (coeff_idx),
        .coeff_last   (coeff_last),
        .cfg_write    (cfg_write),
        .cfg_addr     (cfg_addr),
        .cfg_wdata    (cfg_wdata),
        .cfg_rdata    (cfg_rdata)
    );

    dct_monitor mon_i (
        .clk          (clk),
        .reset        (reset),
        .pixel_valid  (pixel_valid),
        .pixel_credit (pixel_credit),
        .out_credit   (out_credit),
        .dct_out      (dct_out),
        .dct_valid    (dct_valid),
        .coeff_idx    (coeff_idx),
        .coeff_last   (coeff_last),
        .paused       (paused),
        .beat_count   (beat_count),
        .error_count  (mon_errors)
    );

    task automatic step();
        @(posedge clk);
        #10;
    endtask

    function automatic logic [31:0] next_random(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Round half away from zero, clamp to 1023 in magnitude
    function automatic int quantize_ref(input int v, input int sh);
        int mag;
        mag = (v < 0) ? -v : v;
        if (sh > 0) begin
            mag = mag + (1 << (sh - 1));
        end
        mag = mag >> sh;
        if (mag > 1023) begin
            mag = 1023;
        end
        return (v < 0) ? -mag : mag;
    endfunction

    task automatic stop_on_timeout(input string what);
        $display("Timeout while waiting for %s", what);
        $display("Error counts: checker %0d, sequence %0d", mon_errors, other_errors + 1);
        $display("*** FAILED ***");
        $finish;
    endtask

    task automatic wait_beats(input int target);
        int waited;
        waited = 0;
        while (beat_count < target && waited < WAIT_LIMIT) begin
            step();
            waited++;
        end
        if (beat_count < target) begin
            stop_on_timeout("coefficient beats");
        end
    endtask

    task automatic write_reg(input logic [1:0] addr, input logic [7:0] data);
        cfg_write = 1'b1;
        cfg_addr  = addr;
        cfg_wdata = data;
        step();
        cfg_write = 1'b0;
    endtask

    task automatic check_reg(input logic [1:0] addr, input logic [7:0] exp);
        cfg_addr = addr;
        step();
        if (cfg_rdata !== exp) begin
            $display("MISMATCH cfg_rdata addr %h: expected %h, got %h", addr, exp, cfg_rdata);
            other_errors++;
        end
    endtask

    task automatic make_pixels(input row_t row, output int px [BLK_PIX]);
        for (int i = 0; i < BLK_PIX; i++) begin
            case (row.mode)
                FILL_CONST: px[i] = row.value;
                FILL_RAMP:  px[i] = (i * row.value) & 8'hff;
                default: begin
                    rng   = next_random(rng);
                    px[i] = rng[7:0];
                end
            endcase
        end
    endtask

    // Reference Y = C * X * C^T, then quantize and queue in zigzag order
    task automatic push_expected(input int px [BLK_PIX], input int sh,
                                 input logic dc_known, input int dc_exp);
        int x [BLK_PIX];
        int r [BLK_PIX];
        int y [BLK_PIX];
        int q;
        for (int i = 0; i < BLK_PIX; i++) begin
            x[i] = px[i] - 128;
        end
        for (int row = 0; row < BLK_DIM; row++) begin
            for (int k = 0; k < BLK_DIM; k++) begin
                r[row*BLK_DIM+k] = 0;
                for (int c = 0; c < BLK_DIM; c++) begin
                    r[row*BLK_DIM+k] += CORE[k][c] * x[row*BLK_DIM+c];
                end
            end
        end
        for (int k = 0; k < BLK_DIM; k++) begin
            for (int c = 0; c < BLK_DIM; c++) begin
                y[k*BLK_DIM+c] = 0;
                for (int j = 0; j < BLK_DIM; j++) begin
                    y[k*BLK_DIM+c] += CORE[k][j] * r[j*BLK_DIM+c];
                end
            end
        end
        for (int z = 0; z < BLK_PIX; z++) begin
            q = quantize_ref(y[ZIGZAG[z]], sh);
            // Rows with a known DC expect the table value on the first beat
            if (z == 0 && dc_known) begin
                q = dc_exp;
            end
            mon_i.expect_beat(q[OUT_W-1:0], ZIGZAG[z], z == BLK_PIX - 1);
        end
    endtask

    task automatic send_pixel(input int p);
        int waited;
        waited = 0;
        while (up_credits == 0 && waited < WAIT_LIMIT) begin
            step();
            waited++;
        end
        if (up_credits == 0) begin
            stop_on_timeout("a pixel credit");
        end
        pixel_in    = p[PIX_W-1:0];
        pixel_valid = 1'b1;
        step();
        pixel_valid = 1'b0;
    endtask

    // Output held off for a number of cycles in the middle of a block
    task automatic pause_output(input int cycles);
        write_reg(REG_CTRL, {4'b0, cur_shift, 1'b0});
        step();
        paused = 1'b1;
        repeat (cycles) step();
        paused = 1'b0;
        write_reg(REG_CTRL, {4'b0, cur_shift, 1'b1});
    endtask

    // Upstream credit model
    always @(posedge clk) begin
        if (reset) begin
            up_credits <= PIXEL_CREDITS;
        end else begin
            up_credits <= up_credits + int'(pixel_credit) - int'(pixel_valid);
        end
    end

    // Downstream returns one credit per beat, spaced by credit_gap cycles
    always begin
        step();
        if (reset) begin
            owed       = 0;
            gap_cnt    = 0;
            out_credit = 1'b0;
        end else begin
            if (dct_valid) begin
                owed++;
            end
            if (owed > 0 && gap_cnt >= credit_gap) begin
                out_credit = 1'b1;
                owed--;
                gap_cnt = 0;
            end else begin
                out_credit = 1'b0;
                gap_cnt++;
            end
        end
    end

    initial begin
        int px [BLK_PIX];
        int base;
        int waited;
        pixel_in    = '0;
        pixel_valid = 1'b0;
        out_credit  = 1'b0;
        cfg_write   = 1'b0;
        cfg_addr    = REG_CTRL;
        cfg_wdata   = '0;
        paused      = 1'b0;
        waited      = 0;
        #10;
        while (reset && waited < WAIT_LIMIT) begin
            step();
            waited++;
        end
        if (reset) begin
            stop_on_timeout("reset release");
        end

        for (int i = 0; i < NROWS; i++) begin
            credit_gap = ROWS[i].gap;
            // A new shift only applies once earlier blocks have left
            if (ROWS[i].shift != cur_shift) begin
                wait_beats(expected_total);
                cur_shift = ROWS[i].shift;
                write_reg(REG_CTRL, {4'b0, cur_shift, 1'b1});
            end
            base = expected_total;
            make_pixels(ROWS[i], px);
            push_expected(px, ROWS[i].shift, ROWS[i].dc_check, ROWS[i].dc_exp);
            expected_total += BLK_PIX;
            for (int p = 0; p < BLK_PIX; p++) begin
                send_pixel(px[p]);
            end
            if (ROWS[i].pause != 0) begin
                wait_beats(base + 5);
                pause_output(ROWS[i].pause);
            end
        end

        wait_beats(expected_total);
        repeat (20) step();
        check_reg(REG_STATUS, 8'(NROWS));
        // Status is read only
        write_reg(REG_STATUS, 8'h55);
        check_reg(REG_STATUS, 8'(NROWS));
        check_reg(REG_CTRL, {4'b0, cur_shift, 1'b1});
        if (up_credits != PIXEL_CREDITS) begin
            $display("Upstream ended with %0d pixel credits instead of %0d",
                     up_credits, PIXEL_CREDITS);
            other_errors++;
        end

        $display("Error counts: checker %0d, sequence %0d", mon_errors, other_errors);
        if (mon_errors + other_errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: dct_compressor.f
verilog/dct_pkg.sv
verilog/dct_ifs.sv
verilog/block_buffer.sv
verilog/block_transform.sv
verilog/coeff_quantizer.sv
verilog/compressor_regs.sv
verilog/dct_compressor.sv
tests/clock_gen.sv
tests/dct_monitor.sv
tests/tb_dct_compressor.sv

// File: Bender.yml
package:
  name: dct_compressor

sources:
  - files:
      - verilog/dct_pkg.sv
      - verilog/dct_ifs.sv
      - verilog/block_buffer.sv
      - verilog/block_transform.sv
      - verilog/coeff_quantizer.sv
      - verilog/compressor_regs.sv
      - verilog/dct_compressor.sv
  - target: test
    files:
      - tests/clock_gen.sv
      - tests/dct_monitor.sv
      - tests/tb_dct_compressor.sv
